//--- common/glyph_font.svh
//------------------------------
// Hex digit font, 0 to F only
// Eight row bytes per glyph, row 0 on top
// Bit 7 is the leftmost pixel
// Include inside a module body
//------------------------------
localparam logic [7:0] GLYPH_FONT [16][8] = '{
	'{8'h3C, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3C}, // 0
	'{8'h18, 8'h38, 8'h78, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E}, // 1
	'{8'h3C, 8'h66, 8'h66, 8'h0C, 8'h18, 8'h30, 8'h60, 8'h7E}, // 2
	'{8'h7C, 8'h06, 8'h06, 8'h7C, 8'h06, 8'h06, 8'h06, 8'h7C}, // 3
	'{8'h0E, 8'h16, 8'h26, 8'h46, 8'h46, 8'h7E, 8'h06, 8'h06}, // 4
	'{8'h7E, 8'h60, 8'h60, 8'h78, 8'h0C, 8'h06, 8'h0C, 8'h78}, // 5
	'{8'h3C, 8'h40, 8'h40, 8'h7C, 8'h42, 8'h42, 8'h42, 8'h3C}, // 6
	'{8'h7E, 8'h06, 8'h06, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h60}, // 7
	'{8'h3C, 8'h42, 8'h42, 8'h3C, 8'h42, 8'h42, 8'h42, 8'h3C}, // 8
	'{8'h3C, 8'h46, 8'h46, 8'h46, 8'h3E, 8'h06, 8'h06, 8'h06}, // 9
	'{8'h3C, 8'h42, 8'h42, 8'h42, 8'h7E, 8'h42, 8'h42, 8'h42}, // A
	'{8'h7C, 8'h42, 8'h46, 8'h7C, 8'h46, 8'h42, 8'h42, 8'h7C}, // B
	'{8'h3E, 8'h60, 8'h60, 8'h60, 8'h60, 8'h60, 8'h60, 8'h3E}, // C
	'{8'h7C, 8'h62, 8'h62, 8'h62, 8'h62, 8'h62, 8'h62, 8'h7C}, // D
	'{8'h3E, 8'h60, 8'h60, 8'h7E, 8'h60, 8'h60, 8'h60, 8'h3E}, // E
	'{8'h7E, 8'h60, 8'h60, 8'h7E, 8'h60, 8'h60, 8'h60, 8'h60}  // F
};

//--- common/charview_pkg.sv
//------------------------------
// Geometry assumes a 640x480 byte-per-line frame buffer
// Eight pixels per byte, one byte per character column
// Character rows are ten pixel lines tall
// Field placement is fixed, there is no offset
//------------------------------
package charview_pkg;

	// Screen geometry
	localparam int SCREEN_COLS = 80; // Characters per line
	localparam int LINE_PITCH = SCREEN_COLS; // Bytes per pixel line
	localparam int ROW_PITCH = 800; // Eight glyph lines plus two blank lines
	localparam int GLYPH_LINES = 8;

	// Field table
	localparam int NUM_GP_REGS = 8;
	localparam int NUM_FIELDS = 9; // GP registers then cycle counter
	localparam int WORD_W = 32;
	localparam int CYCLE_W = 16;
	localparam int FB_ADDR_W = 16;

	// Placement in character cells
	localparam int GP_COL = 63;
	localparam int GP_ROW_BASE = 14;
	localparam int GP_ROW_STEP = 3; // Blank rows between registers
	localparam int CYC_COL = 8;
	localparam int CYC_ROW = 35;

	// One hex character headed for the glyph stage
	typedef struct packed {
		logic [3:0] digit; // Hex digit code 0..F
		logic [6:0] col;
		logic [5:0] row;
		logic last; // Final character of a pass
	} char_item_t;

	// One byte write into the frame buffer
	typedef struct packed {
		logic [FB_ADDR_W-1:0] addr;
		logic [7:0] data;
		logic last; // Final write of a pass
	} fb_write_t;

	// All GP register values side by side, register 0 in the low word
	typedef logic [NUM_GP_REGS-1:0][WORD_W-1:0] gp_regs_t;

endpackage

//--- src/pipe_reg.sv
`timescale 1ns/100ps
//------------------------------
// Single-entry valid/ready stage
// Full throughput, one cycle of latency
// Payload type set by parameter
//------------------------------
module pipe_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	// Room when empty or draining this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clock) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

	a_out_stable: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("output changed under back-pressure");

endmodule

//--- src/field_sequencer.sv
`timescale 1ns/100ps
//------------------------------
// A pass starts only on start while idle
// All nine values are sampled on that same edge
// Order is GP0..GP7 then cycles, MSB digit first
// scan_busy drops once the last item is handed over
//------------------------------
module field_sequencer (
	input  logic                             clock,
	input  logic                             rst_n,
	input  logic                             start,
	input  charview_pkg::gp_regs_t           gp_regs,
	input  logic [charview_pkg::CYCLE_W-1:0] cycle_count,
	input  logic                             item_ready,
	output logic                             scan_busy,
	output logic                             item_valid,
	output charview_pkg::char_item_t         item
);

	charview_pkg::gp_regs_t snap_gp; // Values frozen for the pass
	logic [charview_pkg::CYCLE_W-1:0] snap_cyc;
	logic [3:0] field_cnt;
	logic [2:0] digit_cnt;
	logic is_cyc;
	logic [3:0] field_digits;
	logic last_digit;
	logic [2:0] nib_sel;
	logic [charview_pkg::WORD_W-1:0] cur_word;
	logic take;

	assign item_valid = scan_busy;
	assign take = item_valid && item_ready;
	assign is_cyc = (field_cnt == 4'(charview_pkg::NUM_FIELDS - 1)); // Cycle counter is last
	assign field_digits = is_cyc ? 4'(charview_pkg::CYCLE_W / 4) : 4'(charview_pkg::WORD_W / 4);
	assign last_digit = ({1'b0, digit_cnt} == field_digits - 4'd1);
	assign nib_sel = 3'(field_digits - 4'd1 - {1'b0, digit_cnt}); // Nibble index from LSB

	always_comb begin
		cur_word = '0;
		if (is_cyc)
			cur_word[charview_pkg::CYCLE_W-1:0] = snap_cyc;
		else
			cur_word = snap_gp[field_cnt[2:0]];
	end

	always_comb begin
		item.digit = cur_word[{nib_sel, 2'b00} +: 4];
		item.last = is_cyc && last_digit;
		if (is_cyc) begin
			item.col = 7'(charview_pkg::CYC_COL + digit_cnt);
			item.row = 6'(charview_pkg::CYC_ROW);
		end else begin
			item.col = 7'(charview_pkg::GP_COL + digit_cnt);
			item.row = 6'(charview_pkg::GP_ROW_BASE + charview_pkg::GP_ROW_STEP * field_cnt);
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			scan_busy <= 1'b0;
			field_cnt <= '0;
			digit_cnt <= '0;
		end else if (!scan_busy) begin
			scan_busy <= start; // Counters already at zero here
		end else if (take) begin
			if (last_digit) begin
				digit_cnt <= '0;
				if (is_cyc) begin
					field_cnt <= '0;
					scan_busy <= 1'b0; // Pass handed over
				end else begin
					field_cnt <= field_cnt + 4'd1;
				end
			end else begin
				digit_cnt <= digit_cnt + 3'd1;
			end
		end
	end

	// Snapshot, starts while busy are ignored
	always_ff @(posedge clock) begin
		if (start && !scan_busy) begin
			snap_gp <= gp_regs;
			snap_cyc <= cycle_count;
		end
	end

	a_digit_in_field: assert property (@(posedge clock) disable iff (!rst_n)
		{1'b0, digit_cnt} < field_digits)
		else $error("digit counter past field width");

	a_item_held: assert property (@(posedge clock) disable iff (!rst_n)
		item_valid && !item_ready |=> item_valid && $stable(item))
		else $error("item changed while stalled");

endmodule

//--- src/glyph_expander.sv
`timescale 1ns/100ps
//------------------------------
// One char item becomes eight row writes
// Takes a new item only when idle
// so there is one bubble between characters
//------------------------------
module glyph_expander (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     item_valid,
	input  charview_pkg::char_item_t item,
	output logic                     item_ready,
	input  logic                     wr_ready,
	output logic                     wr_valid,
	output charview_pkg::fb_write_t  wr
);

	`include "glyph_font.svh"

	charview_pkg::char_item_t cur_item; // Character being drawn
	logic [2:0] line_cnt;
	logic active;
	logic last_line;

	assign item_ready = !active;
	assign wr_valid = active;
	assign last_line = (line_cnt == 3'(charview_pkg::GLYPH_LINES - 1));

	always_comb begin
		wr.addr = charview_pkg::FB_ADDR_W'(
			charview_pkg::ROW_PITCH * cur_item.row +
			charview_pkg::LINE_PITCH * line_cnt +
			cur_item.col);
		wr.data = GLYPH_FONT[cur_item.digit][line_cnt];
		wr.last = cur_item.last && last_line; // Only the very last byte
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active <= 1'b0;
			line_cnt <= '0;
		end else if (item_valid && item_ready) begin
			active <= 1'b1;
			line_cnt <= '0;
		end else if (wr_valid && wr_ready) begin
			if (last_line)
				active <= 1'b0;
			line_cnt <= line_cnt + 3'd1; // Wraps back to zero after line 7
		end
	end

	always_ff @(posedge clock) begin
		if (item_valid && item_ready)
			cur_item <= item;
	end

	// Counter has to be back at zero before the next item may enter
	a_idle_line: assert property (@(posedge clock) disable iff (!rst_n)
		(line_cnt != 3'd0) |-> !item_ready)
		else $error("item_ready high mid-glyph");

endmodule

//--- src/char_engine_top.sv
`timescale 1ns/100ps
//------------------------------
// Renders GP registers and cycle count as hex
// One start pulse gives exactly 544 byte writes
// Write port is a single valid/ready pair, no response
//------------------------------
module char_engine_top (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic                               start,
	input  charview_pkg::gp_regs_t             gp_regs,
	input  logic [charview_pkg::CYCLE_W-1:0]   cycle_count,
	output logic                               scan_busy,
	output logic                               fb_valid,
	input  logic                               fb_ready,
	output logic [charview_pkg::FB_ADDR_W-1:0] fb_addr,
	output logic [7:0]                         fb_data,
	output logic                               fb_last
);

	logic seq_valid, seq_ready; // Sequencer to item stage
	charview_pkg::char_item_t seq_item;
	logic chr_valid, chr_ready; // Item stage to expander
	charview_pkg::char_item_t chr_item;
	logic exp_valid, exp_ready; // Expander to write stage
	charview_pkg::fb_write_t exp_wr;
	charview_pkg::fb_write_t out_wr;

	field_sequencer u_field_sequencer (
		.clock       (clock),
		.rst_n       (rst_n),
		.start       (start),
		.gp_regs     (gp_regs),
		.cycle_count (cycle_count),
		.item_ready  (seq_ready),
		.scan_busy   (scan_busy),
		.item_valid  (seq_valid),
		.item        (seq_item)
	);

	pipe_reg #(.payload_t(charview_pkg::char_item_t)) u_item_stage (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (seq_valid),
		.in_data   (seq_item),
		.in_ready  (seq_ready),
		.out_valid (chr_valid),
		.out_data  (chr_item),
		.out_ready (chr_ready)
	);

	glyph_expander u_glyph_expander (
		.clock      (clock),
		.rst_n      (rst_n),
		.item_valid (chr_valid),
		.item       (chr_item),
		.item_ready (chr_ready),
		.wr_ready   (exp_ready),
		.wr_valid   (exp_valid),
		.wr         (exp_wr)
	);

	pipe_reg #(.payload_t(charview_pkg::fb_write_t)) u_write_stage (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (exp_valid),
		.in_data   (exp_wr),
		.in_ready  (exp_ready),
		.out_valid (fb_valid),
		.out_data  (out_wr),
		.out_ready (fb_ready)
	);

	assign fb_addr = out_wr.addr;
	assign fb_data = out_wr.data;
	assign fb_last = out_wr.last;

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps
//------------------------------
// 10 ns clock, starts low
// rst_n low for the first three rising edges
//------------------------------
module tb_clock_gen (
	output logic clock,
	output logic rst_n
);

	localparam int HALF_PERIOD = 5; // ns

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clock);
		rst_n <= 1'b1; // Released on the third edge
	end

endmodule

//--- verification/tb_char_engine.sv
`timescale 1ns/100ps
//------------------------------
// Directed tests for char_engine_top
// Expected writes come from the address rule and the font table
// Outputs are sampled on the falling edge
//------------------------------
module tb_char_engine;

	localparam int PASS_WRITES = 544; // 68 digits of 8 lines
	localparam int PASS_TIMEOUT = 4000; // Cycles allowed per pass
	localparam int IDLE_TIMEOUT = 2000;

	`include "glyph_font.svh"

	logic clock;
	logic rst_n;
	logic start;
	charview_pkg::gp_regs_t gp_regs;
	logic [charview_pkg::CYCLE_W-1:0] cycle_count;
	logic fb_ready;
	logic scan_busy;
	logic fb_valid;
	logic [charview_pkg::FB_ADDR_W-1:0] fb_addr;
	logic [7:0] fb_data;
	logic fb_last;

	logic [charview_pkg::FB_ADDR_W-1:0] exp_addr [PASS_WRITES];
	logic [7:0] exp_data [PASS_WRITES];
	integer seed = 32'h9e5b_22e4;
	int checks = 0;
	int errors = 0;

	tb_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

	char_engine_top u_dut (
		.clock       (clock),
		.rst_n       (rst_n),
		.start       (start),
		.gp_regs     (gp_regs),
		.cycle_count (cycle_count),
		.scan_busy   (scan_busy),
		.fb_valid    (fb_valid),
		.fb_ready    (fb_ready),
		.fb_addr     (fb_addr),
		.fb_data     (fb_data),
		.fb_last     (fb_last)
	);

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// Write list in screen order: fields, MSB digit first, lines 0..7
	task automatic build_expected(input charview_pkg::gp_regs_t regs, input logic [15:0] cyc);
		int n;
		int digits;
		int col0;
		int row;
		logic [31:0] value;
		logic [3:0] nib;
		n = 0;
		for (int f = 0; f < charview_pkg::NUM_FIELDS; f++) begin
			if (f < charview_pkg::NUM_GP_REGS) begin
				value = regs[f];
				digits = 8;
				col0 = charview_pkg::GP_COL;
				row = charview_pkg::GP_ROW_BASE + charview_pkg::GP_ROW_STEP * f;
			end else begin
				value = {16'h0000, cyc};
				digits = 4;
				col0 = charview_pkg::CYC_COL;
				row = charview_pkg::CYC_ROW;
			end
			for (int d = 0; d < digits; d++) begin
				nib = 4'((value >> (4 * (digits - 1 - d))) & 32'hF);
				for (int line = 0; line < 8; line++) begin
					exp_addr[n] = 16'(charview_pkg::ROW_PITCH * row +
						charview_pkg::LINE_PITCH * line + col0 + d);
					exp_data[n] = GLYPH_FONT[nib][line];
					n++;
				end
			end
		end
	endtask

	task automatic random_values(output charview_pkg::gp_regs_t regs, output logic [15:0] cyc);
		for (int i = 0; i < charview_pkg::NUM_GP_REGS; i++)
			regs[i] = $random(seed);
		cyc = 16'($random(seed));
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		@(negedge clock);
		while (scan_busy && waited < IDLE_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (scan_busy)
			note_failure("Timeout: scan_busy never dropped");
	endtask

	// Takes every accepted write until fb_last, optionally toggling fb_ready
	task automatic collect_pass(input bit random_ready);
		int idx;
		int waited;
		bit done;
		bit held;
		logic [charview_pkg::FB_ADDR_W-1:0] held_addr;
		logic [7:0] held_data;
		idx = 0;
		waited = 0;
		done = 1'b0;
		held = 1'b0;
		while (!done && waited < PASS_TIMEOUT) begin
			@(negedge clock);
			waited++;
			if (held) begin
				compare_value("fb_valid held", fb_valid, 1'b1);
				compare_value("fb_addr held", fb_addr, held_addr);
				compare_value("fb_data held", fb_data, held_data);
			end
			held = fb_valid && !fb_ready;
			held_addr = fb_addr;
			held_data = fb_data;
			if (fb_valid && fb_ready) begin
				if (idx < PASS_WRITES) begin
					compare_value("fb_addr", fb_addr, exp_addr[idx]);
					compare_value("fb_data", fb_data, exp_data[idx]);
					compare_value("fb_last", fb_last, idx == PASS_WRITES - 1);
				end else begin
					note_failure("Write seen past the end of the pass");
				end
				idx++;
				done = fb_last;
			end
			@(posedge clock);
			fb_ready <= random_ready ? 1'($random(seed)) : 1'b1;
		end
		if (!done)
			note_failure("Timeout: pass ended without fb_last");
		compare_value("write count", idx, PASS_WRITES);
	endtask

	task automatic run_pass(input charview_pkg::gp_regs_t regs, input logic [15:0] cyc,
		input bit random_ready, input bit change_after);
		wait_idle();
		build_expected(regs, cyc);
		@(posedge clock);
		gp_regs <= regs;
		cycle_count <= cyc;
		fb_ready <= 1'b1;
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
		if (change_after) begin
			gp_regs <= ~regs; // Snapshot must already hold regs
			cycle_count <= ~cyc;
		end
		@(negedge clock);
		compare_value("scan_busy", scan_busy, 1'b1);
		collect_pass(random_ready);
	endtask

	task automatic check_reset_state();
		int waited;
		waited = 0;
		while (!rst_n && waited < 20) begin
			@(negedge clock);
			waited++;
		end
		if (!rst_n)
			note_failure("Timeout: reset was never released");
		repeat (20) begin
			@(negedge clock);
			compare_value("fb_valid", fb_valid, 1'b0);
			compare_value("scan_busy", scan_busy, 1'b0);
		end
	endtask

	task automatic render_known_values();
		charview_pkg::gp_regs_t regs;
		regs[0] = 32'h0123_4567;
		regs[1] = 32'h89AB_CDEF;
		regs[2] = 32'hFEDC_BA98;
		regs[3] = 32'h7654_3210;
		regs[4] = 32'h0000_0000;
		regs[5] = 32'hFFFF_FFFF;
		regs[6] = 32'hDEAD_BEEF;
		regs[7] = 32'h5A5A_A5A5;
		run_pass(regs, 16'hC0DE, 1'b0, 1'b0);
	endtask

	task automatic render_random_values();
		charview_pkg::gp_regs_t regs;
		logic [15:0] cyc;
		repeat (3) begin
			random_values(regs, cyc);
			run_pass(regs, cyc, 1'b0, 1'b0);
		end
	endtask

	task automatic stall_output();
		charview_pkg::gp_regs_t regs;
		logic [15:0] cyc;
		repeat (2) begin
			random_values(regs, cyc);
			run_pass(regs, cyc, 1'b1, 1'b0);
		end
	endtask

	task automatic verify_snapshot();
		charview_pkg::gp_regs_t regs;
		logic [15:0] cyc;
		random_values(regs, cyc);
		run_pass(regs, cyc, 1'b0, 1'b1);
	endtask

	task automatic pulse_start_while_busy();
		repeat (40) @(negedge clock);
		compare_value("scan_busy at second start", scan_busy, 1'b1);
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic ignore_start_while_busy();
		charview_pkg::gp_regs_t regs;
		logic [15:0] cyc;
		int extra;
		random_values(regs, cyc);
		fork
			run_pass(regs, cyc, 1'b0, 1'b0);
			pulse_start_while_busy();
		join
		extra = 0;
		repeat (100) begin
			@(negedge clock);
			if (fb_valid)
				extra++;
		end
		compare_value("writes after fb_last", extra, 0);
		compare_value("scan_busy", scan_busy, 1'b0);
	endtask

	initial begin
		start = 1'b0;
		fb_ready = 1'b1;
		gp_regs = '0;
		cycle_count = '0;
		check_reset_state();
		render_known_values();
		render_random_values();
		stall_output();
		verify_snapshot();
		ignore_start_while_busy();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/charview_pkg.sv
src/pipe_reg.sv
src/field_sequencer.sv
src/glyph_expander.sv
src/char_engine_top.sv
verification/tb_clock_gen.sv
verification/tb_char_engine.sv

//--- Bender.yml
package:
  name: char_engine

sources:
  - include_dirs:
      - common
    files:
      - common/charview_pkg.sv
      - src/pipe_reg.sv
      - src/field_sequencer.sv
      - src/glyph_expander.sv
      - src/char_engine_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_char_engine.sv
